// ==== source/mini_mcu_pkg.sv ====
// ##########################################################################
// bits 31:28 of an address select the region; codes other than RAM and
// peripheral are unmapped and answer with an error
// ##########################################################################

package mini_mcu_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = 4;

  // field widths of the two address views
  localparam int REGION_W = 4;
  localparam int WORD_W   = 26;
  localparam int REG_W    = 4;

  localparam logic [REGION_W-1:0] REGION_RAM    = 4'h0;
  localparam logic [REGION_W-1:0] REGION_PERIPH = 4'h1;

  localparam logic [REG_W-1:0] REG_EXIT    = 4'd0;
  localparam logic [REG_W-1:0] REG_SCRATCH = 4'd1;
  localparam logic [REG_W-1:0] REG_ID      = 4'd2;

  // "mcu1" in ascii
  localparam logic [DATA_W-1:0] MCU_ID = 32'h6d63_7531;

  // one bus address seen either as a RAM word or as a peripheral register
  typedef union packed {
    struct packed {
      logic [REGION_W-1:0] region;
      logic [WORD_W-1:0]   word;
      logic [1:0]          offset;
    } ram;
    struct packed {
      logic [REGION_W-1:0] region;
      logic [21:0]         unused;
      logic [REG_W-1:0]    reg_idx;
      logic [1:0]          offset;
    } periph;
  } bus_addr_u;

endpackage

// ==== source/system_bus.sv ====
// ##########################################################################
// grants at most one master per cycle, in the same cycle as its request
// targets must answer exactly one cycle after their select
// ##########################################################################
`timescale 1ns/1ps

module system_bus
  import mini_mcu_pkg::*;
#(
  parameter int NUM_MASTERS = 2
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,

  input  logic [NUM_MASTERS-1:0]              m_req_i,
  input  logic [NUM_MASTERS-1:0]              m_we_i,
  input  logic [NUM_MASTERS-1:0][BE_W-1:0]    m_be_i,
  input  logic [NUM_MASTERS-1:0][ADDR_W-1:0]  m_addr_i,
  input  logic [NUM_MASTERS-1:0][DATA_W-1:0]  m_wdata_i,
  output logic [NUM_MASTERS-1:0]              m_gnt_o,
  output logic [NUM_MASTERS-1:0]              m_rvalid_o,
  output logic [NUM_MASTERS-1:0][DATA_W-1:0]  m_rdata_o,
  output logic [NUM_MASTERS-1:0]              m_err_o,

  output logic                                ram_sel_o,
  output logic                                ram_we_o,
  output logic [BE_W-1:0]                     ram_be_o,
  output logic [WORD_W-1:0]                   ram_word_o,
  output logic [DATA_W-1:0]                   ram_wdata_o,
  input  logic [DATA_W-1:0]                   ram_rdata_i,

  output logic                                periph_sel_o,
  output logic                                periph_we_o,
  output logic [BE_W-1:0]                     periph_be_o,
  output logic [REG_W-1:0]                    periph_reg_o,
  output logic [DATA_W-1:0]                   periph_wdata_o,
  input  logic [DATA_W-1:0]                   periph_rdata_i
);

  localparam int MIDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;
  localparam logic [MIDX_W-1:0] LAST_M = MIDX_W'(NUM_MASTERS - 1);

  logic [MIDX_W-1:0]   prio_q;
  logic [MIDX_W-1:0]   win;
  logic                any_gnt;
  bus_addr_u           win_addr;
  logic [REGION_W-1:0] win_region;

  logic                rsp_valid_q;
  logic [MIDX_W-1:0]   rsp_master_q;
  logic [REGION_W-1:0] rsp_region_q;
  logic [DATA_W-1:0]   rsp_data;
  logic                rsp_unmapped;

  // first requester at or after the priority pointer wins
  always_comb begin : arbiter
    int cand;
    m_gnt_o = '0;
    win     = '0;
    any_gnt = 1'b0;
    for (int k = 0; k < NUM_MASTERS; k++) begin
      cand = int'(prio_q) + k;
      if (cand >= NUM_MASTERS) begin
        cand = cand - NUM_MASTERS;
      end
      if (!any_gnt && m_req_i[cand]) begin
        any_gnt       = 1'b1;
        win           = MIDX_W'(cand);
        m_gnt_o[cand] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q <= '0;
    end else if (any_gnt) begin
      prio_q <= (win == LAST_M) ? '0 : win + 1'b1;
    end
  end

  // address decode of the winner
  assign win_addr   = m_addr_i[win];
  assign win_region = win_addr.ram.region;

  assign ram_sel_o   = any_gnt && (win_region == REGION_RAM);
  assign ram_we_o    = m_we_i[win];
  assign ram_be_o    = m_be_i[win];
  assign ram_word_o  = win_addr.ram.word;
  assign ram_wdata_o = m_wdata_i[win];

  assign periph_sel_o   = any_gnt && (win_region == REGION_PERIPH);
  assign periph_we_o    = m_we_i[win];
  assign periph_be_o    = m_be_i[win];
  assign periph_reg_o   = win_addr.periph.reg_idx;
  assign periph_wdata_o = m_wdata_i[win];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= any_gnt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (any_gnt) begin
      rsp_master_q <= win;
      rsp_region_q <= win_region;
    end
  end

  // unmapped accesses return zero data with err set
  assign rsp_unmapped = (rsp_region_q != REGION_RAM) && (rsp_region_q != REGION_PERIPH);
  assign rsp_data     = (rsp_region_q == REGION_RAM)    ? ram_rdata_i :
                        (rsp_region_q == REGION_PERIPH) ? periph_rdata_i : '0;

  always_comb begin
    m_rvalid_o = '0;
    m_rdata_o  = '0;
    m_err_o    = '0;
    if (rsp_valid_q) begin
      m_rvalid_o[rsp_master_q] = 1'b1;
      m_rdata_o[rsp_master_q]  = rsp_data;
      m_err_o[rsp_master_q]    = rsp_unmapped;
    end
  end

endmodule

// ==== source/memory_bank.sv ====
// ##########################################################################
// RAM_WORDS must be a power of two; the word index wraps modulo the depth
// contents are undefined after reset
// ##########################################################################
`timescale 1ns/1ps

module memory_bank
  import mini_mcu_pkg::*;
#(
  parameter int RAM_WORDS = 256
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              sel_i,
  input  logic              we_i,
  input  logic [BE_W-1:0]   be_i,
  input  logic [WORD_W-1:0] word_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o
);

  localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  logic [DATA_W-1:0] mem_q [RAM_WORDS];
  logic [IDX_W-1:0]  idx;

  // upper index bits are dropped, so large addresses alias
  assign idx = word_i[IDX_W-1:0];

  always_ff @(posedge clk_i) begin
    if (sel_i && we_i) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be_i[b]) begin
          mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // zero on writes and idle cycles
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_o <= '0;
    end else if (sel_i && !we_i) begin
      rdata_o <= mem_q[idx];
    end else begin
      rdata_o <= '0;
    end
  end

endmodule

// ==== source/peripheral_regs.sv ====
// ##########################################################################
// exit write ignores byte enables; exit_valid_o is sticky until reset
// ##########################################################################
`timescale 1ns/1ps

module peripheral_regs
  import mini_mcu_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              sel_i,
  input  logic              we_i,
  input  logic [BE_W-1:0]   be_i,
  input  logic [REG_W-1:0]  reg_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic [DATA_W-1:0] exit_value_o,
  output logic              exit_valid_o
);

  logic [DATA_W-1:0] scratch_q;
  logic [DATA_W-1:0] read_mux;

  always_comb begin
    case (reg_i)
      REG_EXIT:    read_mux = exit_value_o;
      REG_SCRATCH: read_mux = scratch_q;
      REG_ID:      read_mux = MCU_ID;
      default:     read_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_value_o <= '0;
      exit_valid_o <= 1'b0;
      scratch_q    <= '0;
    end else if (sel_i && we_i) begin
      case (reg_i)
        REG_EXIT: begin
          exit_value_o <= wdata_i;
          exit_valid_o <= 1'b1;
        end
        REG_SCRATCH: begin
          for (int b = 0; b < BE_W; b++) begin
            if (be_i[b]) begin
              scratch_q[8*b +: 8] <= wdata_i[8*b +: 8];
            end
          end
        end
        // id and unused indices drop writes
        default: ;
      endcase
    end
  end

  // read data one cycle after select, zero for writes
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_o <= '0;
    end else if (sel_i && !we_i) begin
      rdata_o <= read_mux;
    end else begin
      rdata_o <= '0;
    end
  end

endmodule

// ==== source/mini_mcu.sv ====
// ##########################################################################
// external masters share one bus; each must hold req and payload until gnt
// response arrives one cycle after the grant for every region
// ##########################################################################
`timescale 1ns/1ps

module mini_mcu
  import mini_mcu_pkg::*;
#(
  parameter int NUM_MASTERS = 2,
  parameter int RAM_WORDS   = 256
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,

  input  logic [NUM_MASTERS-1:0]              m_req_i,
  input  logic [NUM_MASTERS-1:0]              m_we_i,
  input  logic [NUM_MASTERS-1:0][BE_W-1:0]    m_be_i,
  input  logic [NUM_MASTERS-1:0][ADDR_W-1:0]  m_addr_i,
  input  logic [NUM_MASTERS-1:0][DATA_W-1:0]  m_wdata_i,
  output logic [NUM_MASTERS-1:0]              m_gnt_o,
  output logic [NUM_MASTERS-1:0]              m_rvalid_o,
  output logic [NUM_MASTERS-1:0][DATA_W-1:0]  m_rdata_o,
  output logic [NUM_MASTERS-1:0]              m_err_o,

  output logic [DATA_W-1:0]                   exit_value_o,
  output logic                                exit_valid_o
);

  // bus to RAM
  logic              ram_sel;
  logic              ram_we;
  logic [BE_W-1:0]   ram_be;
  logic [WORD_W-1:0] ram_word;
  logic [DATA_W-1:0] ram_wdata;
  logic [DATA_W-1:0] ram_rdata;

  // bus to peripheral registers
  logic              periph_sel;
  logic              periph_we;
  logic [BE_W-1:0]   periph_be;
  logic [REG_W-1:0]  periph_reg;
  logic [DATA_W-1:0] periph_wdata;
  logic [DATA_W-1:0] periph_rdata;

  system_bus #(
    .NUM_MASTERS(NUM_MASTERS)
  ) i_system_bus (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .m_req_i       (m_req_i),
    .m_we_i        (m_we_i),
    .m_be_i        (m_be_i),
    .m_addr_i      (m_addr_i),
    .m_wdata_i     (m_wdata_i),
    .m_gnt_o       (m_gnt_o),
    .m_rvalid_o    (m_rvalid_o),
    .m_rdata_o     (m_rdata_o),
    .m_err_o       (m_err_o),
    .ram_sel_o     (ram_sel),
    .ram_we_o      (ram_we),
    .ram_be_o      (ram_be),
    .ram_word_o    (ram_word),
    .ram_wdata_o   (ram_wdata),
    .ram_rdata_i   (ram_rdata),
    .periph_sel_o  (periph_sel),
    .periph_we_o   (periph_we),
    .periph_be_o   (periph_be),
    .periph_reg_o  (periph_reg),
    .periph_wdata_o(periph_wdata),
    .periph_rdata_i(periph_rdata)
  );

  memory_bank #(
    .RAM_WORDS(RAM_WORDS)
  ) i_memory_bank (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .sel_i   (ram_sel),
    .we_i    (ram_we),
    .be_i    (ram_be),
    .word_i  (ram_word),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

  peripheral_regs i_peripheral_regs (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .sel_i       (periph_sel),
    .we_i        (periph_we),
    .be_i        (periph_be),
    .reg_i       (periph_reg),
    .wdata_i     (periph_wdata),
    .rdata_o     (periph_rdata),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

endmodule

// ==== test/mini_mcu_checker.sv ====
// ##########################################################################
// master side protocol checks that bind to every mini_mcu instance
// ##########################################################################
`timescale 1ns/1ps

module mini_mcu_checker #(
  parameter int NUM_MASTERS = 2
) (
  input logic                   clk_i,
  input logic                   arst_n_i,
  input logic [NUM_MASTERS-1:0] req_i,
  input logic [NUM_MASTERS-1:0] gnt_i,
  input logic [NUM_MASTERS-1:0] rvalid_i,
  input logic                   exit_valid_i
);

  gnt_onehot: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $onehot0(gnt_i)
  ) else $error("more than one master granted in a cycle");

  gnt_has_req: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) (gnt_i & ~req_i) == '0
  ) else $error("grant given to a master without a request");

  // response returns to the granted master one cycle later
  rvalid_after_gnt: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) gnt_i != '0 |=> rvalid_i == $past(gnt_i)
  ) else $error("rvalid does not follow the grant");

  exit_sticky: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) exit_valid_i |=> exit_valid_i
  ) else $error("exit_valid_o fell outside reset");

endmodule

bind mini_mcu mini_mcu_checker #(
  .NUM_MASTERS(NUM_MASTERS)
) i_checker (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .req_i       (m_req_i),
  .gnt_i       (m_gnt_o),
  .rvalid_i    (m_rvalid_o),
  .exit_valid_i(exit_valid_o)
);

// ==== test/tb_mini_mcu.sv ====
// ##########################################################################
// two masters with xorshift traffic checked against a model of the map
// RAM is filled first because its contents are not reset
// ##########################################################################
`timescale 1ns/1ps

module tb_mini_mcu
  import mini_mcu_pkg::*;
();

  localparam int NUM_M         = 2;
  localparam int RAM_WORDS     = 256;
  localparam int N_RAM         = 600;
  localparam int N_ARB         = 100;
  localparam int N_PERIPH      = 120;
  localparam int N_EXIT        = 4;
  localparam int N_UNMAPPED    = 60;
  localparam int N_CONFIRM     = 32;
  localparam int TOTAL_XFERS   = RAM_WORDS + N_RAM + N_ARB + N_PERIPH + N_EXIT
                                 + N_UNMAPPED + N_CONFIRM;
  localparam int CYCLE_LIMIT   = 4 * TOTAL_XFERS + 100;
  localparam int KIND_RAM      = 0;
  localparam int KIND_PERIPH   = 1;
  localparam int KIND_UNMAPPED = 2;

  typedef struct packed {
    logic              we;
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } xfer_t;

  logic                          clk;
  logic                          arst_n;
  logic [NUM_M-1:0]              m_req;
  logic [NUM_M-1:0]              m_we;
  logic [NUM_M-1:0][BE_W-1:0]    m_be;
  logic [NUM_M-1:0][ADDR_W-1:0]  m_addr;
  logic [NUM_M-1:0][DATA_W-1:0]  m_wdata;
  logic [NUM_M-1:0]              m_gnt;
  logic [NUM_M-1:0]              m_rvalid;
  logic [NUM_M-1:0][DATA_W-1:0]  m_rdata;
  logic [NUM_M-1:0]              m_err;
  logic [DATA_W-1:0]             exit_value;
  logic                          exit_valid;

  // model state
  logic [DATA_W-1:0] ram_m [RAM_WORDS];
  logic [DATA_W-1:0] scratch_m;
  logic [DATA_W-1:0] exit_value_m;
  logic              exit_valid_m;
  int                prio_m;
  xfer_t             plan_q [NUM_M][$];
  logic [DATA_W:0]   exp_q [NUM_M][$];
  xfer_t             cur [NUM_M];
  logic [NUM_M-1:0]  pending;
  logic [NUM_M-1:0]  rsp_due;
  logic [31:0]       rng_state;
  int                cycle_cnt = 0;

  mini_mcu #(
    .NUM_MASTERS(NUM_M),
    .RAM_WORDS  (RAM_WORDS)
  ) i_dut (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .m_req_i     (m_req),
    .m_we_i      (m_we),
    .m_be_i      (m_be),
    .m_addr_i    (m_addr),
    .m_wdata_i   (m_wdata),
    .m_gnt_o     (m_gnt),
    .m_rvalid_o  (m_rvalid),
    .m_rdata_o   (m_rdata),
    .m_err_o     (m_err),
    .exit_value_o(exit_value),
    .exit_valid_o(exit_valid)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Testbench failed");
      $fatal(1, "timeout");
    end
  end

  task automatic report_error(string msg);
    $display("FAIL %0t ns: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1, "check failed");
  endtask

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(logic [DATA_W-1:0] old_w,
                                                    logic [DATA_W-1:0] new_w,
                                                    logic [BE_W-1:0] be);
    logic [DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // first requester at or after the round-robin pointer wins
  function automatic logic [NUM_M-1:0] expected_grant(logic [NUM_M-1:0] req, int prio);
    logic [NUM_M-1:0] g;
    int m;
    g = '0;
    for (int k = 0; k < NUM_M; k++) begin
      m = (prio + k) % NUM_M;
      if (req[m] && g == '0) begin
        g[m] = 1'b1;
      end
    end
    return g;
  endfunction

  function automatic xfer_t random_xfer(int kind, logic force_read);
    xfer_t     x;
    bus_addr_u a;
    logic [31:0] r;
    logic [31:0] c;
    r = xorshift32();
    c = xorshift32();
    a = r;
    if (kind == KIND_RAM) begin
      a.ram.region = REGION_RAM;
      // half the words stay below the depth, the rest alias
      if (c[31]) begin
        a.ram.word = 26'(r[9:2]);
      end
    end else if (kind == KIND_PERIPH) begin
      a.periph.region = REGION_PERIPH;
      case (c[21:20])
        2'd1:    a.periph.reg_idx = REG_ID;
        2'd2:    a.periph.reg_idx = 4'(3 + (c[27:24] % 13));
        default: a.periph.reg_idx = REG_SCRATCH;
      endcase
    end else begin
      a.ram.region = 4'(2 + (c[27:24] % 14));
    end
    x.addr  = a;
    x.we    = force_read ? 1'b0 : c[30];
    x.be    = c[3:0];
    x.wdata = xorshift32();
    return x;
  endfunction

  function automatic xfer_t periph_access(logic we, logic [REG_W-1:0] idx,
                                          logic [DATA_W-1:0] wdata);
    xfer_t x;
    x.we    = we;
    x.be    = '1;
    x.addr  = {REGION_PERIPH, 22'd0, idx, 2'd0};
    x.wdata = wdata;
    return x;
  endfunction

  task automatic plan_random(int kind, int count, logic force_read);
    for (int i = 0; i < count; i++) begin
      plan_q[i % NUM_M].push_back(random_xfer(kind, force_read));
    end
  endtask

  task automatic apply_transfer(int m, xfer_t x);
    bus_addr_u         a;
    int                idx;
    logic [DATA_W-1:0] rsp;
    logic              err;
    a   = x.addr;
    rsp = '0;
    err = 1'b0;
    idx = int'(a.ram.word) % RAM_WORDS;
    if (a.ram.region == REGION_RAM) begin
      if (x.we) begin
        ram_m[idx] = merge_bytes(ram_m[idx], x.wdata, x.be);
      end else begin
        rsp = ram_m[idx];
      end
    end else if (a.periph.region == REGION_PERIPH) begin
      if (x.we && a.periph.reg_idx == REG_EXIT) begin
        exit_value_m = x.wdata;
        exit_valid_m = 1'b1;
      end else if (x.we && a.periph.reg_idx == REG_SCRATCH) begin
        scratch_m = merge_bytes(scratch_m, x.wdata, x.be);
      end else if (!x.we) begin
        case (a.periph.reg_idx)
          REG_EXIT:    rsp = exit_value_m;
          REG_SCRATCH: rsp = scratch_m;
          REG_ID:      rsp = MCU_ID;
          default:     rsp = '0;
        endcase
      end
    end else begin
      err = 1'b1;
    end
    exp_q[m].push_back({err, rsp});
  endtask

  task automatic check_outputs();
    logic [DATA_W:0] exp;
    assert (exit_valid === exit_valid_m)
      else report_error($sformatf("exit_valid_o is %b, expected %b", exit_valid, exit_valid_m));
    assert (exit_value === exit_value_m)
      else report_error($sformatf("exit_value_o is %h, expected %h", exit_value, exit_value_m));
    assert (m_rvalid === rsp_due)
      else report_error($sformatf("rvalid is %b, expected %b", m_rvalid, rsp_due));
    for (int m = 0; m < NUM_M; m++) begin
      if (rsp_due[m]) begin
        exp = exp_q[m].pop_front();
        assert ({m_err[m], m_rdata[m]} === exp)
          else report_error($sformatf("master %0d err %b rdata %h, expected err %b rdata %h",
                                      m, m_err[m], m_rdata[m], exp[DATA_W], exp[DATA_W-1:0]));
      end
    end
  endtask

  task automatic process_grants();
    logic [NUM_M-1:0] exp_gnt;
    exp_gnt = expected_grant(m_req, prio_m);
    assert (m_gnt === exp_gnt)
      else report_error($sformatf("gnt is %b for req %b, expected %b", m_gnt, m_req, exp_gnt));
    for (int m = 0; m < NUM_M; m++) begin
      if (m_gnt[m]) begin
        apply_transfer(m, cur[m]);
        pending[m] = 1'b0;
        prio_m     = (m + 1) % NUM_M;
      end
    end
    rsp_due = m_gnt;
  endtask

  // idle masters pick up their next planned transfer with chance busy percent
  task automatic drive_requests(int busy);
    for (int m = 0; m < NUM_M; m++) begin
      if (!pending[m] && plan_q[m].size() > 0 && (xorshift32() % 100) < busy) begin
        cur[m]     = plan_q[m].pop_front();
        pending[m] = 1'b1;
      end
      m_req[m]   = pending[m];
      m_we[m]    = cur[m].we;
      m_be[m]    = cur[m].be;
      m_addr[m]  = cur[m].addr;
      m_wdata[m] = cur[m].wdata;
    end
  endtask

  task automatic step_cycle(int busy);
    @(negedge clk);
    check_outputs();
    process_grants();
    @(posedge clk);
    #1;
    drive_requests(busy);
  endtask

  task automatic run_phase(int busy);
    while (plan_q[0].size() > 0 || plan_q[1].size() > 0 || pending != '0 || rsp_due != '0) begin
      step_cycle(busy);
    end
  endtask

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    m_req        = '0;
    m_we         = '0;
    m_be         = '0;
    m_addr       = '0;
    m_wdata      = '0;
    rng_state    = 32'h50b8;
    scratch_m    = '0;
    exit_value_m = '0;
    exit_valid_m = 1'b0;
    prio_m       = 0;
    pending      = '0;
    rsp_due      = '0;
    for (int m = 0; m < NUM_M; m++) begin
      cur[m] = '0;
    end

    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    repeat (4) step_cycle(0);
    assert (exit_valid === 1'b0 && exit_value === '0)
      else report_error("exit outputs were not cleared by reset");

    // each word's fill value mixes in its full byte address
    for (int w = 0; w < RAM_WORDS; w++) begin
      plan_q[0].push_back('{1'b1, 4'hf, ADDR_W'(w * 4), 32'h9e37_79b1 * 32'(w * 4 + 1)});
    end
    run_phase(100);

    plan_random(KIND_RAM, N_RAM, 1'b0);
    run_phase(60);
    // both masters request every cycle, so grants must alternate
    plan_random(KIND_RAM, N_ARB, 1'b0);
    run_phase(100);
    plan_random(KIND_PERIPH, N_PERIPH, 1'b0);
    run_phase(70);

    plan_q[0].push_back(periph_access(1'b1, REG_EXIT, 32'h0000_0e11));
    plan_q[1].push_back(periph_access(1'b0, REG_EXIT, '0));
    plan_q[0].push_back(periph_access(1'b1, REG_EXIT, 32'h0000_0bad));
    plan_q[1].push_back(periph_access(1'b0, REG_EXIT, '0));
    run_phase(100);
    assert (exit_valid === 1'b1 && exit_value === 32'h0000_0bad)
      else report_error("second exit write did not update exit_value_o");

    plan_random(KIND_UNMAPPED, N_UNMAPPED, 1'b0);
    run_phase(50);
    plan_random(KIND_RAM, N_CONFIRM / 2, 1'b1);
    plan_random(KIND_PERIPH, N_CONFIRM / 2, 1'b1);
    run_phase(80);

    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== mini_mcu.f ====
source/mini_mcu_pkg.sv
source/system_bus.sv
source/memory_bank.sv
source/peripheral_regs.sv
source/mini_mcu.sv
test/mini_mcu_checker.sv
test/tb_mini_mcu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the mini_mcu testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_mini_mcu -f mini_mcu.f -o sim_tb_mini_mcu
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb_mini_mcu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
  echo "simulation PASS"
  exit 0
else
  echo "simulation FAIL"
  exit 1
fi
